/* sdr_core.f */
+incdir+src
src/core_pkg.sv
src/regport_ctrl.sv
src/global_regs.sv
src/route_table.sv
src/pkt_router.sv
src/sdr_core.sv
test/sdr_core_tb.sv

/* src/core_macros.svh */
// Widths, register map and constant values for the control core
// Register offsets are byte addresses and must stay word aligned
// Route table range is RT_BASE up to RT_BASE + 4 * (RT_ENTRIES - 1)
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Register port widths
`define REG_AWIDTH     14
`define REG_DWIDTH     32

// Stream widths
`define PKT_WIDTH      64
`define DST_WIDTH      16
`define DEV_AW         8

// Output ports and port select width
`define NUM_PORTS      4
`define PORT_W         2
`define UPLINK_PORT    2'd0

// Global register map
`define REG_BUILD_ID   14'h000
`define REG_NUM_PORTS  14'h004
`define REG_LOCAL_ADDR 14'h008
`define REG_SCRATCH    14'h00C

// Route table map, one word per entry
`define RT_BASE        14'h100
`define RT_ENTRIES     16
`define RT_IDX_W       4

// Data values
`define SCRATCH_RST    32'h0000_0002
`define CORE_BUILD_ID  32'h5d31_0a7c
`define UNMAPPED_DATA  32'hBAD0_0000

`endif

/* src/core_pkg.sv */
// Shared types for the control core
// Widths come from core_macros.svh, which must be on the include path
`include "core_macros.svh"

package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Register port
  ////////////////////////////////////////////////////////////////////////////

  // Byte address of a register
  typedef logic [`REG_AWIDTH-1:0] reg_addr_t;

  // Register read and write data
  typedef logic [`REG_DWIDTH-1:0] reg_data_t;

  ////////////////////////////////////////////////////////////////////////////
  // Stream
  ////////////////////////////////////////////////////////////////////////////

  // One stream word
  typedef logic [`PKT_WIDTH-1:0] pkt_word_t;

  // Destination in bits 15:0 of the first word
  // Device byte on top, endpoint byte below
  typedef struct packed {
    logic [`DEV_AW-1:0] dev;
    logic [`DEV_AW-1:0] ep;
  } dst_addr_t;

  // Binary output port number
  typedef logic [`PORT_W-1:0] port_sel_t;

endpackage

/* src/global_regs.sv */
// Global register block: build id, port count, local address, scratch
// Build id and port count are read only; undefined offsets read as zero
// Read data is registered one cycle after the read strobe
`timescale 1ns/100ps
`include "core_macros.svh"

module global_regs (
  input  logic                bus_clk,
  input  logic                bus_rst,
  input  logic                i_wr_stb,
  input  logic                i_rd_stb,
  input  core_pkg::reg_addr_t i_wr_addr,
  input  core_pkg::reg_addr_t i_rd_addr,
  input  core_pkg::reg_data_t i_wr_data,
  output core_pkg::reg_data_t o_rd_data,
  output logic [`DEV_AW-1:0]  o_local_addr,
  output logic [2:0]          o_spi_mux,
  output logic                o_cpld_reset
);

  import core_pkg::*;

  // Word offsets inside the global range
  localparam logic [5:0] OFS_BUILD_ID   = 6'(`REG_BUILD_ID >> 2);
  localparam logic [5:0] OFS_NUM_PORTS  = 6'(`REG_NUM_PORTS >> 2);
  localparam logic [5:0] OFS_LOCAL_ADDR = 6'(`REG_LOCAL_ADDR >> 2);
  localparam logic [5:0] OFS_SCRATCH    = 6'(`REG_SCRATCH >> 2);

  logic [5:0]         wr_ofs;
  logic [5:0]         rd_ofs;
  reg_data_t          scratch;
  logic [`DEV_AW-1:0] local_addr;

  // Byte lane bits ignored
  assign wr_ofs = i_wr_addr[7:2];
  assign rd_ofs = i_rd_addr[7:2];

  ////////////////////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      scratch    <= `SCRATCH_RST;
      local_addr <= '0;
    end else if (i_wr_stb) begin
      case (wr_ofs)
        OFS_SCRATCH:    scratch <= i_wr_data;
        OFS_LOCAL_ADDR: local_addr <= i_wr_data[`DEV_AW-1:0];
        // Build id and port count drop writes
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read back
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (i_rd_stb) begin
      case (rd_ofs)
        OFS_BUILD_ID:   o_rd_data <= `CORE_BUILD_ID;
        OFS_NUM_PORTS:  o_rd_data <= reg_data_t'(`NUM_PORTS);
        OFS_LOCAL_ADDR: o_rd_data <= reg_data_t'(local_addr);
        OFS_SCRATCH:    o_rd_data <= scratch;
        default:        o_rd_data <= '0;
      endcase
    end
  end

  // Board controls taken from scratch
  assign o_spi_mux    = scratch[2:0];
  assign o_cpld_reset = scratch[3];
  assign o_local_addr = local_addr;

endmodule

/* src/pkt_router.sv */
// Packet router, one input stream to NUM_PORTS one-hot output strobes
// Route is picked at the first word and held until the last word
// No back-pressure; every word leaves one cycle after it arrives
`timescale 1ns/100ps
`include "core_macros.svh"

module pkt_router (
  input  logic                    bus_clk,
  input  logic                    bus_rst,
  // Input stream
  input  logic                    i_pkt_stb,
  input  core_pkg::pkt_word_t     i_pkt_data,
  input  logic                    i_pkt_last,
  // Routing context
  input  logic [`DEV_AW-1:0]      i_local_addr,
  output logic [`RT_IDX_W-1:0]    o_lookup_idx,
  input  core_pkg::port_sel_t     i_lookup_port,
  // Output stream
  output logic [`NUM_PORTS-1:0]   o_port_stb,
  output core_pkg::pkt_word_t     o_pkt_data,
  output logic                    o_pkt_last
);

  import core_pkg::*;

  dst_addr_t dst;
  logic      first_word;
  logic      dev_match;
  port_sel_t held_port;
  port_sel_t cur_port;

  ////////////////////////////////////////////////////////////////////////////
  // Route selection
  ////////////////////////////////////////////////////////////////////////////

  // Header fields, meaningful only on a first word
  assign dst          = dst_addr_t'(i_pkt_data[`DST_WIDTH-1:0]);
  assign o_lookup_idx = dst.ep[`RT_IDX_W-1:0];
  assign dev_match    = (dst.dev == i_local_addr);

  // Fresh decision on first word, otherwise reuse the held port
  always_comb begin
    if (first_word) begin
      cur_port = dev_match ? i_lookup_port : `UPLINK_PORT;
    end else begin
      cur_port = held_port;
    end
  end

  // Packet boundary tracking
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      first_word <= 1'b1;
      held_port  <= `UPLINK_PORT;
    end else if (i_pkt_stb) begin
      // Next word starts a packet once this one closes
      first_word <= i_pkt_last;
      if (first_word) begin
        held_port <= cur_port;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_port_stb <= '0;
      o_pkt_last <= 1'b0;
    end else begin
      o_pkt_last <= i_pkt_stb && i_pkt_last;
      // One-hot decode of the chosen port
      for (int p = 0; p < `NUM_PORTS; p++) begin
        o_port_stb[p] <= i_pkt_stb && (cur_port == port_sel_t'(p));
      end
    end
  end

  // Data only moves with a strobe
  always_ff @(posedge bus_clk) begin
    if (i_pkt_stb) begin
      o_pkt_data <= i_pkt_data;
    end
  end

endmodule

/* src/regport_ctrl.sv */
// Register port front end for the control core
// Read response comes exactly 2 cycles after the request, reads may issue
// every cycle; writes land on the next edge and unmapped writes are dropped
`timescale 1ns/100ps
`include "core_macros.svh"

module regport_ctrl (
  input  logic                bus_clk,
  input  logic                bus_rst,
  // External register port
  input  logic                i_wr_req,
  input  core_pkg::reg_addr_t i_wr_addr,
  input  core_pkg::reg_data_t i_wr_data,
  input  logic                i_rd_req,
  input  core_pkg::reg_addr_t i_rd_addr,
  output logic                o_rd_resp,
  output core_pkg::reg_data_t o_rd_data,
  output logic                o_rd_err,
  // Block strobes and shared address/data
  output logic                o_glb_wr_stb,
  output logic                o_glb_rd_stb,
  output logic                o_rt_wr_stb,
  output logic                o_rt_rd_stb,
  output core_pkg::reg_addr_t o_blk_wr_addr,
  output core_pkg::reg_addr_t o_blk_rd_addr,
  output core_pkg::reg_data_t o_blk_wr_data,
  // Registered read data from the blocks
  input  core_pkg::reg_data_t i_glb_rd_data,
  input  core_pkg::reg_data_t i_rt_rd_data
);

  import core_pkg::*;

  // Last route table word address
  localparam reg_addr_t RT_LAST = reg_addr_t'(`RT_BASE + 4 * (`RT_ENTRIES - 1));

  // Read source held between the two pipeline stages
  typedef enum logic [1:0] {
    SRC_GLB,
    SRC_RT,
    SRC_NONE
  } rd_src_t;

  logic    rd_pend;
  rd_src_t rd_src;

  // Global block owns everything below the route table
  function automatic logic in_glb(input reg_addr_t addr);
    return addr < reg_addr_t'(`RT_BASE);
  endfunction

  function automatic logic in_rt(input reg_addr_t addr);
    return (addr >= reg_addr_t'(`RT_BASE)) && (addr <= RT_LAST);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Strobes follow the request in the same cycle
  assign o_glb_wr_stb = i_wr_req && in_glb(i_wr_addr);
  assign o_rt_wr_stb  = i_wr_req && in_rt(i_wr_addr);
  assign o_glb_rd_stb = i_rd_req && in_glb(i_rd_addr);
  assign o_rt_rd_stb  = i_rd_req && in_rt(i_rd_addr);

  // Blocks decode their own offsets
  assign o_blk_wr_addr = i_wr_addr;
  assign o_blk_rd_addr = i_rd_addr;
  assign o_blk_wr_data = i_wr_data;

  ////////////////////////////////////////////////////////////////////////////
  // Stage one: note who was read
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      rd_pend <= 1'b0;
      rd_src  <= SRC_NONE;
    end else begin
      rd_pend <= i_rd_req;
      // Unmapped read keeps the error source
      if (o_glb_rd_stb) begin
        rd_src <= SRC_GLB;
      end else if (o_rt_rd_stb) begin
        rd_src <= SRC_RT;
      end else begin
        rd_src <= SRC_NONE;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage two: merge block data into the response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_rd_resp <= 1'b0;
      o_rd_err  <= 1'b0;
    end else begin
      o_rd_resp <= rd_pend;
      o_rd_err  <= rd_pend && (rd_src == SRC_NONE);
    end
  end

  // Block data is valid only in the cycle after its strobe
  always_ff @(posedge bus_clk) begin
    if (rd_pend) begin
      case (rd_src)
        SRC_GLB: o_rd_data <= i_glb_rd_data;
        SRC_RT:  o_rd_data <= i_rt_rd_data;
        default: o_rd_data <= `UNMAPPED_DATA;
      endcase
    end
  end

endmodule

/* src/route_table.sv */
// Endpoint to output port table, sixteen entries
// Entries take data bits 1:0 and read back zero extended
// Lookup is combinational so a write shows on the next cycle
`timescale 1ns/100ps
`include "core_macros.svh"

module route_table (
  input  logic                   bus_clk,
  input  logic                   bus_rst,
  input  logic                   i_wr_stb,
  input  logic                   i_rd_stb,
  input  core_pkg::reg_addr_t    i_wr_addr,
  input  core_pkg::reg_addr_t    i_rd_addr,
  input  core_pkg::reg_data_t    i_wr_data,
  output core_pkg::reg_data_t    o_rd_data,
  input  logic [`RT_IDX_W-1:0]   i_lookup_idx,
  output core_pkg::port_sel_t    o_lookup_port
);

  import core_pkg::*;

  port_sel_t            table_q [`RT_ENTRIES];
  logic [`RT_IDX_W-1:0] wr_idx;
  logic [`RT_IDX_W-1:0] rd_idx;

  // Entry index is the word offset from RT_BASE
  assign wr_idx = i_wr_addr[`RT_IDX_W+1:2];
  assign rd_idx = i_rd_addr[`RT_IDX_W+1:2];

  // All entries point at the uplink after reset
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      for (int n = 0; n < `RT_ENTRIES; n++) begin
        table_q[n] <= `UPLINK_PORT;
      end
    end else if (i_wr_stb) begin
      table_q[wr_idx] <= i_wr_data[`PORT_W-1:0];
    end
  end

  // Register read back
  always_ff @(posedge bus_clk) begin
    if (i_rd_stb) begin
      o_rd_data <= reg_data_t'(table_q[rd_idx]);
    end
  end

  // Router side
  assign o_lookup_port = table_q[i_lookup_idx];

endmodule

/* src/sdr_core.sv */
// Top level of the bus-clock control core
// Register port and stream enter as loose strobe ports, no back-pressure
// Everything runs on bus_clk with synchronous reset bus_rst
`timescale 1ns/100ps
`include "core_macros.svh"

module sdr_core (
  input  logic                  bus_clk,
  input  logic                  bus_rst,
  // Register port
  input  logic                  i_wr_req,
  input  core_pkg::reg_addr_t   i_wr_addr,
  input  core_pkg::reg_data_t   i_wr_data,
  input  logic                  i_rd_req,
  input  core_pkg::reg_addr_t   i_rd_addr,
  output logic                  o_rd_resp,
  output core_pkg::reg_data_t   o_rd_data,
  output logic                  o_rd_err,
  // Stream in
  input  logic                  i_pkt_stb,
  input  core_pkg::pkt_word_t   i_pkt_data,
  input  logic                  i_pkt_last,
  // Stream out
  output logic [`NUM_PORTS-1:0] o_port_stb,
  output core_pkg::pkt_word_t   o_pkt_data,
  output logic                  o_pkt_last,
  // Board controls
  output logic [2:0]            o_spi_mux,
  output logic                  o_cpld_reset
);

  import core_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////////////////////

  logic                 glb_wr_stb;
  logic                 glb_rd_stb;
  logic                 rt_wr_stb;
  logic                 rt_rd_stb;
  reg_addr_t            blk_wr_addr;
  reg_addr_t            blk_rd_addr;
  reg_data_t            blk_wr_data;
  reg_data_t            glb_rd_data;
  reg_data_t            rt_rd_data;
  logic [`DEV_AW-1:0]   local_addr;
  logic [`RT_IDX_W-1:0] lookup_idx;
  port_sel_t            lookup_port;

  // Register decode and response pipeline
  regport_ctrl regport_ctrl_inst (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_wr_req      (i_wr_req),
    .i_wr_addr     (i_wr_addr),
    .i_wr_data     (i_wr_data),
    .i_rd_req      (i_rd_req),
    .i_rd_addr     (i_rd_addr),
    .o_rd_resp     (o_rd_resp),
    .o_rd_data     (o_rd_data),
    .o_rd_err      (o_rd_err),
    .o_glb_wr_stb  (glb_wr_stb),
    .o_glb_rd_stb  (glb_rd_stb),
    .o_rt_wr_stb   (rt_wr_stb),
    .o_rt_rd_stb   (rt_rd_stb),
    .o_blk_wr_addr (blk_wr_addr),
    .o_blk_rd_addr (blk_rd_addr),
    .o_blk_wr_data (blk_wr_data),
    .i_glb_rd_data (glb_rd_data),
    .i_rt_rd_data  (rt_rd_data)
  );

  global_regs global_regs_inst (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .i_wr_stb     (glb_wr_stb),
    .i_rd_stb     (glb_rd_stb),
    .i_wr_addr    (blk_wr_addr),
    .i_rd_addr    (blk_rd_addr),
    .i_wr_data    (blk_wr_data),
    .o_rd_data    (glb_rd_data),
    .o_local_addr (local_addr),
    .o_spi_mux    (o_spi_mux),
    .o_cpld_reset (o_cpld_reset)
  );

  route_table route_table_inst (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_wr_stb      (rt_wr_stb),
    .i_rd_stb      (rt_rd_stb),
    .i_wr_addr     (blk_wr_addr),
    .i_rd_addr     (blk_rd_addr),
    .i_wr_data     (blk_wr_data),
    .o_rd_data     (rt_rd_data),
    .i_lookup_idx  (lookup_idx),
    .o_lookup_port (lookup_port)
  );

  // Stream steering
  pkt_router pkt_router_inst (
    .bus_clk       (bus_clk),
    .bus_rst       (bus_rst),
    .i_pkt_stb     (i_pkt_stb),
    .i_pkt_data    (i_pkt_data),
    .i_pkt_last    (i_pkt_last),
    .i_local_addr  (local_addr),
    .o_lookup_idx  (lookup_idx),
    .i_lookup_port (lookup_port),
    .o_port_stb    (o_port_stb),
    .o_pkt_data    (o_pkt_data),
    .o_pkt_last    (o_pkt_last)
  );

endmodule

/* test/sdr_core_tb.sv */
// Directed testbench for the control core
// Register reads and stream words are checked by monitors on the falling edge
// Expected values come from testbench models of scratch, local address and routes
`timescale 1ns/100ps
`include "core_macros.svh"

module sdr_core_tb;

  import core_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;

  logic                  bus_clk;
  logic                  bus_rst;
  logic                  i_wr_req;
  reg_addr_t             i_wr_addr;
  reg_data_t             i_wr_data;
  logic                  i_rd_req;
  reg_addr_t             i_rd_addr;
  logic                  o_rd_resp;
  reg_data_t             o_rd_data;
  logic                  o_rd_err;
  logic                  i_pkt_stb;
  pkt_word_t             i_pkt_data;
  logic                  i_pkt_last;
  logic [`NUM_PORTS-1:0] o_port_stb;
  pkt_word_t             o_pkt_data;
  logic                  o_pkt_last;
  logic [2:0]            o_spi_mux;
  logic                  o_cpld_reset;

  integer    seed = 32'h4e4e_3d51;
  int        cycles = 0;
  // Testbench models of the writable state
  reg_data_t sc_model;
  logic [7:0] local_model;
  port_sel_t rt_model [`RT_ENTRIES];
  // Outstanding reads and words with the oldest first
  reg_data_t rd_data_q [$];
  logic      rd_err_q [$];
  int        rd_due_q [$];
  pkt_word_t wd_data_q [$];
  port_sel_t wd_port_q [$];
  logic      wd_last_q [$];
  int        wd_due_q [$];

  sdr_core sdr_core_inst (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .i_wr_req     (i_wr_req),
    .i_wr_addr    (i_wr_addr),
    .i_wr_data    (i_wr_data),
    .i_rd_req     (i_rd_req),
    .i_rd_addr    (i_rd_addr),
    .o_rd_resp    (o_rd_resp),
    .o_rd_data    (o_rd_data),
    .o_rd_err     (o_rd_err),
    .i_pkt_stb    (i_pkt_stb),
    .i_pkt_data   (i_pkt_data),
    .i_pkt_last   (i_pkt_last),
    .o_port_stb   (o_port_stb),
    .o_pkt_data   (o_pkt_data),
    .o_pkt_last   (o_pkt_last),
    .o_spi_mux    (o_spi_mux),
    .o_cpld_reset (o_cpld_reset)
  );

  // 40 ns period
  initial bus_clk = 1'b0;
  always #20 bus_clk = ~bus_clk;

  ////////////////////////////////////////////////////////////////////////////
  // Error handling and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Stopping after the first error");
  endtask

  task automatic check_reg(input reg_data_t got_data, input logic got_err,
                           input reg_data_t exp_data, input logic exp_err);
    if (got_data !== exp_data || got_err !== exp_err) begin
      abort_run($sformatf("FAILED at %0t: read data %h err %b, expected %h err %b",
                          $time, got_data, got_err, exp_data, exp_err));
    end
  endtask

  task automatic check_word(input pkt_word_t got_data, input port_sel_t got_port,
                            input logic got_last, input pkt_word_t exp_data,
                            input port_sel_t exp_port, input logic exp_last);
    if (got_data !== exp_data || got_port !== exp_port || got_last !== exp_last) begin
      abort_run($sformatf("FAILED at %0t: word %h port %0d last %b, expected %h port %0d last %b",
                          $time, got_data, got_port, got_last, exp_data, exp_port, exp_last));
    end
  endtask

  task automatic check_ctrl(input logic [2:0] got_mux, input logic got_rst,
                            input logic [2:0] exp_mux, input logic exp_rst);
    if (got_mux !== exp_mux || got_rst !== exp_rst) begin
      abort_run($sformatf("FAILED at %0t: spi mux %0d cpld reset %b, expected %0d and %b",
                          $time, got_mux, got_rst, exp_mux, exp_rst));
    end
  endtask

  // Binary port number of a one-hot strobe
  function automatic port_sel_t port_of_strobe(input logic [`NUM_PORTS-1:0] stb);
    port_sel_t p;
    p = '0;
    for (int i = 0; i < `NUM_PORTS; i++) begin
      if (stb[i]) p = port_sel_t'(i);
    end
    return p;
  endfunction

  // Own device byte routes by the table, any other device to the uplink
  function automatic port_sel_t expected_port(input dst_addr_t dst);
    if (dst.dev == local_model) return rt_model[dst.ep[3:0]];
    return port_sel_t'(0);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Timeout and monitors
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge bus_clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // Register responses are due 2 cycles after the request
  always @(negedge bus_clk) begin
    if (!bus_rst) begin
      if (o_rd_resp) begin
        if (rd_due_q.size() == 0) begin
          abort_run("Read response seen with no read outstanding");
        end
        if (rd_due_q[0] != cycles) begin
          abort_run($sformatf("Read response at cycle %0d, expected at cycle %0d",
                              cycles, rd_due_q[0]));
        end
        check_reg(o_rd_data, o_rd_err, rd_data_q[0], rd_err_q[0]);
        void'(rd_data_q.pop_front());
        void'(rd_err_q.pop_front());
        void'(rd_due_q.pop_front());
      end else if (o_rd_err) begin
        abort_run("Read error flag high without a read response");
      end else if (rd_due_q.size() != 0 && rd_due_q[0] <= cycles) begin
        abort_run($sformatf("Read response missing at cycle %0d", cycles));
      end
    end
  end

  // Stream words are due 1 cycle after the input strobe
  always @(negedge bus_clk) begin
    if (!bus_rst) begin
      if (o_port_stb != '0) begin
        if ($countones(o_port_stb) != 1) begin
          abort_run($sformatf("More than one port strobe high: %b", o_port_stb));
        end
        if (wd_due_q.size() == 0) begin
          abort_run("Port strobe seen with no input word outstanding");
        end
        if (wd_due_q[0] != cycles) begin
          abort_run($sformatf("Output word at cycle %0d, expected at cycle %0d",
                              cycles, wd_due_q[0]));
        end
        check_word(o_pkt_data, port_of_strobe(o_port_stb), o_pkt_last,
                   wd_data_q[0], wd_port_q[0], wd_last_q[0]);
        void'(wd_data_q.pop_front());
        void'(wd_port_q.pop_front());
        void'(wd_last_q.pop_front());
        void'(wd_due_q.pop_front());
      end else if (o_pkt_last) begin
        abort_run("Last flag high without a port strobe");
      end else if (wd_due_q.size() != 0 && wd_due_q[0] <= cycles) begin
        abort_run($sformatf("Output word missing at cycle %0d", cycles));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Drive tasks
  ////////////////////////////////////////////////////////////////////////////

  // Step one cycle
  // Strobes drop unless the caller raises them again
  task automatic next_cycle();
    @(posedge bus_clk);
    #1;
    i_wr_req   = 1'b0;
    i_rd_req   = 1'b0;
    i_pkt_stb  = 1'b0;
    i_pkt_last = 1'b0;
  endtask

  task automatic issue_write(input reg_addr_t addr, input reg_data_t data);
    next_cycle();
    i_wr_req  = 1'b1;
    i_wr_addr = addr;
    i_wr_data = data;
  endtask

  task automatic issue_read(input reg_addr_t addr, input reg_data_t exp_data,
                            input logic exp_err);
    next_cycle();
    i_rd_req  = 1'b1;
    i_rd_addr = addr;
    rd_data_q.push_back(exp_data);
    rd_err_q.push_back(exp_err);
    rd_due_q.push_back(cycles + 2);
  endtask

  task automatic send_word(input pkt_word_t data, input logic last, input port_sel_t port);
    next_cycle();
    i_pkt_stb  = 1'b1;
    i_pkt_data = data;
    i_pkt_last = last;
    wd_data_q.push_back(data);
    wd_port_q.push_back(port);
    wd_last_q.push_back(last);
    wd_due_q.push_back(cycles + 1);
  endtask

  task automatic send_packet(input logic [7:0] dev, input logic [7:0] ep, input int len);
    pkt_word_t w;
    port_sel_t p;
    p = expected_port({dev, ep});
    for (int i = 0; i < len; i++) begin
      w = {$random(seed), $random(seed)};
      // Header in the first word only
      if (i == 0) w[15:0] = {dev, ep};
      send_word(w, i == len - 1, p);
    end
  endtask

  // Let every outstanding response drain
  task automatic wait_idle();
    next_cycle();
    while (rd_due_q.size() != 0 || wd_due_q.size() != 0) begin
      next_cycle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_values();
    issue_read(`REG_BUILD_ID, `CORE_BUILD_ID, 1'b0);
    wait_idle();
    issue_read(`REG_NUM_PORTS, 32'd4, 1'b0);
    wait_idle();
    issue_read(`REG_LOCAL_ADDR, 32'd0, 1'b0);
    wait_idle();
    issue_read(`REG_SCRATCH, 32'd2, 1'b0);
    wait_idle();
    check_ctrl(o_spi_mux, o_cpld_reset, 3'd2, 1'b0);
  endtask

  task automatic scratch_writes();
    reg_data_t val;
    for (int i = 0; i < 8; i++) begin
      val = $random(seed);
      sc_model = val;
      issue_write(`REG_SCRATCH, val);
      // Read right after the write sees the new value
      issue_read(`REG_SCRATCH, sc_model, 1'b0);
      wait_idle();
      check_ctrl(o_spi_mux, o_cpld_reset, val[2:0], val[3]);
    end
    // Read-only registers and unmapped writes
    // Unmapped address shares its low bits with scratch
    issue_write(`REG_BUILD_ID, $random(seed));
    issue_write(`REG_NUM_PORTS, $random(seed));
    issue_write(14'h20C, ~sc_model);
    issue_read(`REG_BUILD_ID, `CORE_BUILD_ID, 1'b0);
    issue_read(`REG_NUM_PORTS, 32'd4, 1'b0);
    issue_read(`REG_SCRATCH, sc_model, 1'b0);
    wait_idle();
  endtask

  task automatic back_to_back_reads();
    issue_read(`REG_BUILD_ID, `CORE_BUILD_ID, 1'b0);
    issue_read(reg_addr_t'(`RT_BASE + 12), 32'(rt_model[3]), 1'b0);
    issue_read(14'h200, `UNMAPPED_DATA, 1'b1);
    issue_read(`REG_SCRATCH, sc_model, 1'b0);
    issue_read(14'h3FFC, `UNMAPPED_DATA, 1'b1);
    issue_read(reg_addr_t'(`RT_BASE + 60), 32'(rt_model[15]), 1'b0);
    // First word past the route table
    issue_read(reg_addr_t'(`RT_BASE + 64), `UNMAPPED_DATA, 1'b1);
    issue_read(`REG_LOCAL_ADDR, 32'(local_model), 1'b0);
    issue_read(`REG_NUM_PORTS, 32'd4, 1'b0);
    wait_idle();
  endtask

  task automatic route_table_rw();
    reg_data_t mask;
    reg_data_t val;
    mask = $random(seed);
    for (int n = 0; n < `RT_ENTRIES; n++) begin
      val = $random(seed);
      // Every port appears across the table
      rt_model[n] = port_sel_t'(n[1:0] ^ mask[1:0]);
      issue_write(reg_addr_t'(`RT_BASE + 4 * n), {val[31:2], rt_model[n]});
    end
    for (int n = 0; n < `RT_ENTRIES; n++) begin
      issue_read(reg_addr_t'(`RT_BASE + 4 * n), 32'(rt_model[n]), 1'b0);
    end
    wait_idle();
  endtask

  task automatic local_routing();
    logic [7:0] ep;
    reg_data_t  rnd;
    local_model = 8'h5a;
    issue_write(`REG_LOCAL_ADDR, 32'h0000_005a);
    issue_read(`REG_LOCAL_ADDR, 32'h0000_005a, 1'b0);
    wait_idle();
    // Back-to-back packets
    // Upper endpoint nibble does not index the table
    for (int n = 0; n < `RT_ENTRIES; n++) begin
      rnd = $random(seed);
      ep = {rnd[7:4], 4'(n)};
      send_packet(local_model, ep, 1 + int'(rnd[9:8]));
    end
    wait_idle();
  endtask

  task automatic foreign_routing();
    pkt_word_t w;
    port_sel_t held;
    for (int k = 0; k < 8; k++) begin
      send_packet(local_model ^ (8'h01 << k), 8'(k), 3);
    end
    wait_idle();
    // Route entry rewritten while a local packet is in flight
    held = rt_model[5];
    w = {$random(seed), $random(seed)};
    w[15:0] = {local_model, 8'h05};
    send_word(w, 1'b0, held);
    rt_model[5] = held + 2'd1;
    issue_write(reg_addr_t'(`RT_BASE + 20), 32'(rt_model[5]));
    // Later words repeat the header bits so a fresh lookup would pick the new entry
    for (int i = 0; i < 2; i++) begin
      w = {$random(seed), $random(seed)};
      w[15:0] = {local_model, 8'h05};
      send_word(w, i == 1, held);
    end
    // Following packet takes the new entry
    send_packet(local_model, 8'h05, 2);
    wait_idle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    bus_rst     = 1'b1;
    i_wr_req    = 1'b0;
    i_wr_addr   = '0;
    i_wr_data   = '0;
    i_rd_req    = 1'b0;
    i_rd_addr   = '0;
    i_pkt_stb   = 1'b0;
    i_pkt_data  = '0;
    i_pkt_last  = 1'b0;
    sc_model    = `SCRATCH_RST;
    local_model = 8'h00;
    for (int n = 0; n < `RT_ENTRIES; n++) begin
      rt_model[n] = '0;
    end
    repeat (16) @(posedge bus_clk);
    #1;
    bus_rst = 1'b0;

    reset_values();
    scratch_writes();
    back_to_back_reads();
    route_table_rw();
    local_routing();
    foreign_routing();
    repeat (4) next_cycle();

    if (rd_due_q.size() == 0 && wd_due_q.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run("Run ended with responses still outstanding");
    end
  end

endmodule
